/* rtl/fmSynthPkg.sv */
// widths, sine and bias tables, waveform codes, register selects and the control word union
package fmSynthPkg;

	// channel and datapath widths
	localparam int ChannelCount = 16;
	localparam int ChannelBits = 4;
	localparam int PhaseWidth = 20;
	localparam int TableBits = 6;
	localparam int TableWidth = 8;
	localparam int SampleWidth = 12;
	localparam int AccumWidth = 16;
	localparam int BusWidth = 32;

	// one full sine period, signed 8 bit
	localparam logic signed [TableWidth-1:0] sineTable [1 << TableBits] = '{
		8'h00, 8'h0C, 8'h18, 8'h24, 8'h30, 8'h3B, 8'h46, 8'h50,
		8'h59, 8'h62, 8'h69, 8'h70, 8'h75, 8'h79, 8'h7C, 8'h7E,
		8'h7F, 8'h7E, 8'h7C, 8'h79, 8'h75, 8'h70, 8'h69, 8'h62,
		8'h59, 8'h50, 8'h46, 8'h3B, 8'h30, 8'h24, 8'h18, 8'h0C,
		8'h00, 8'hF4, 8'hE8, 8'hDC, 8'hD0, 8'hC5, 8'hBA, 8'hB0,
		8'hA7, 8'h9E, 8'h97, 8'h90, 8'h8B, 8'h87, 8'h84, 8'h82,
		8'h81, 8'h82, 8'h84, 8'h87, 8'h8B, 8'h90, 8'h97, 8'h9E,
		8'hA7, 8'hB0, 8'hBA, 8'hC5, 8'hD0, 8'hDC, 8'hE8, 8'hF4
	};

	// waveform codes
	localparam logic [3:0] WaveSine = 4'd0;
	localparam logic [3:0] WaveHalf = 4'd1;
	localparam logic [3:0] WaveFull = 4'd2;
	localparam logic [3:0] WaveGated = 4'd3;
	localparam logic [3:0] WaveDouble = 4'd4;
	localparam logic [3:0] WaveDoubleFull = 4'd5;
	localparam logic [3:0] WaveSquare = 4'd6;
	localparam logic [3:0] WaveRamp = 4'd7;

	// dc offset removed per waveform, indexed by code
	localparam logic signed [TableWidth-1:0] biasTable [8] = '{
		8'h00, 8'h28, 8'h50, 8'h28, 8'h00, 8'h28, 8'h00, 8'h00
	};

	// register selects, address bits 4:2
	localparam logic [2:0] RegCtrlA = 3'd0;
	localparam logic [2:0] RegCtrlB = 3'd1;
	localparam logic [2:0] RegPhaseA = 3'd2;
	localparam logic [2:0] RegPhaseB = 3'd3;

	// operator control word
	// bus side sees raw, datapath sees the fields
	typedef union packed {
		logic [BusWidth-1:0] raw;
		struct packed {
			logic [3:0] waveform;
			logic [2:0] shift;
			logic [2:0] attenuation;
			logic modEnable;
			// bit 20, no function
			logic spare;
			logic [PhaseWidth-1:0] freqStep;
		} field;
	} opControl_t;

endpackage

/* rtl/fmChannelRegs.sv */
// per-channel control and phase storage with bus write decode and registered read-back
`timescale 1ns/1ns

module fmChannelRegs
	import fmSynthPkg::*;
(
	input logic clock,
	input logic reset,
	input logic [8:0] address,
	input logic writeStrobe,
	input logic readStrobe,
	input logic [BusWidth-1:0] writeData,
	output logic [BusWidth-1:0] readData,
	output logic readValid,
	input logic [ChannelBits-1:0] scanChannel,
	output opControl_t ctrlA,
	output opControl_t ctrlB,
	output logic [PhaseWidth-1:0] phaseA,
	output logic [PhaseWidth-1:0] phaseB,
	input logic phaseWriteEnable,
	input logic [ChannelBits-1:0] phaseWriteChannel,
	input logic [PhaseWidth-1:0] nextPhaseA,
	input logic [PhaseWidth-1:0] nextPhaseB
);
	opControl_t ctrlAMem [ChannelCount];
	opControl_t ctrlBMem [ChannelCount];
	logic [PhaseWidth-1:0] phaseAMem [ChannelCount];
	logic [PhaseWidth-1:0] phaseBMem [ChannelCount];
	logic [ChannelBits-1:0] busChannel;
	logic [2:0] busSelect;
	logic [BusWidth-1:0] readWord;

	// channel in bits 8:5, register in bits 4:2
	assign busChannel = address[8:5];
	assign busSelect = address[4:2];

	// scan side, answered in the same cycle
	assign ctrlA = ctrlAMem[scanChannel];
	assign ctrlB = ctrlBMem[scanChannel];
	assign phaseA = phaseAMem[scanChannel];
	assign phaseB = phaseBMem[scanChannel];

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < ChannelCount; i++)
			begin
				ctrlAMem[i] <= '0;
				ctrlBMem[i] <= '0;
				phaseAMem[i] <= '0;
				phaseBMem[i] <= '0;
			end
		end
		else
		begin
			// host writes reach control words only
			if (writeStrobe && busSelect == RegCtrlA)
				ctrlAMem[busChannel].raw <= writeData;
			if (writeStrobe && busSelect == RegCtrlB)
				ctrlBMem[busChannel].raw <= writeData;
			// stepped phase from the sequencer
			if (phaseWriteEnable)
			begin
				phaseAMem[phaseWriteChannel] <= nextPhaseA;
				phaseBMem[phaseWriteChannel] <= nextPhaseB;
			end
		end
	end

	// read mux, unused selects read as zero
	always_comb
	begin
		case (busSelect)
			RegCtrlA: readWord = ctrlAMem[busChannel].raw;
			RegCtrlB: readWord = ctrlBMem[busChannel].raw;
			RegPhaseA: readWord = BusWidth'(phaseAMem[busChannel]);
			RegPhaseB: readWord = BusWidth'(phaseBMem[busChannel]);
			default: readWord = '0;
		endcase
	end

	// data one cycle after the strobe
	always_ff @(posedge clock)
	begin
		if (reset)
			readValid <= 1'b0;
		else
			readValid <= readStrobe;
		if (readStrobe)
			readData <= readWord;
	end

	// host issues one access per cycle
	busOneAccess: assert property (@(posedge clock) disable iff (reset)
		!(readStrobe && writeStrobe));

endmodule

/* rtl/fmChannelSequencer.sv */
// frame start, channel walk, operator issue and phase write-back
`timescale 1ns/1ns

module fmChannelSequencer
	import fmSynthPkg::*;
(
	input logic clock,
	input logic reset,
	input logic sampleTick,
	output logic scanValid,
	output logic [ChannelBits-1:0] scanChannel,
	input opControl_t ctrlA,
	input opControl_t ctrlB,
	input logic [PhaseWidth-1:0] phaseA,
	input logic [PhaseWidth-1:0] phaseB,
	output logic issueValid,
	output logic issueLast,
	output opControl_t issueCtrlA,
	output opControl_t issueCtrlB,
	output logic [PhaseWidth-1:0] issuePhaseA,
	output logic [PhaseWidth-1:0] issuePhaseB,
	output logic phaseWriteEnable,
	output logic [ChannelBits-1:0] phaseWriteChannel,
	output logic [PhaseWidth-1:0] nextPhaseA,
	output logic [PhaseWidth-1:0] nextPhaseB
);
	logic scanEnd;
	// operator a waits out the modulator's two stages
	opControl_t ctrlAPipe [3];
	logic [PhaseWidth-1:0] phaseAPipe [3];

	assign scanEnd = scanChannel == ChannelBits'(ChannelCount - 1);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			scanValid <= 1'b0;
			scanChannel <= '0;
			issueValid <= 1'b0;
			issueLast <= 1'b0;
		end
		else
		begin
			issueValid <= scanValid;
			issueLast <= scanValid && scanEnd;
			// a tick mid-walk is dropped
			if (scanValid)
			begin
				scanValid <= !scanEnd;
				scanChannel <= scanChannel + 1'b1;
			end
			else if (sampleTick)
			begin
				scanValid <= 1'b1;
				scanChannel <= '0;
			end
		end
	end

	// issue register, pre-step phase goes out
	always_ff @(posedge clock)
	begin
		issueCtrlB <= ctrlB;
		issuePhaseB <= phaseB;
		ctrlAPipe[0] <= ctrlA;
		phaseAPipe[0] <= phaseA;
		for (int i = 1; i < 3; i++)
		begin
			ctrlAPipe[i] <= ctrlAPipe[i-1];
			phaseAPipe[i] <= phaseAPipe[i-1];
		end
	end

	assign issueCtrlA = ctrlAPipe[2];
	assign issuePhaseA = phaseAPipe[2];

	// write back on the scan cycle, wraps mod 2^20
	assign phaseWriteEnable = scanValid;
	assign phaseWriteChannel = scanChannel;
	assign nextPhaseA = phaseA + ctrlA.field.freqStep;
	assign nextPhaseB = phaseB + ctrlB.field.freqStep;

	// a walk lasts one cycle per channel, no more and no less
	walkLength: assert property (@(posedge clock) disable iff (reset)
		$fell(scanValid) |-> $past(scanValid, ChannelCount) &&
			!$past(scanValid, ChannelCount + 1));

endmodule

/* rtl/fmOperator.sv */
// one fm operator: sine lookup, waveform shaping, bias, attenuation and shift
`timescale 1ns/1ns

module fmOperator
	import fmSynthPkg::*;
(
	input logic clock,
	input logic reset,
	input logic inValid,
	input logic inLast,
	input opControl_t control,
	input logic [PhaseWidth-1:0] phase,
	input logic [TableWidth-1:0] modOffset,
	input logic signed [SampleWidth-1:0] passIn,
	output logic outValid,
	output logic outLast,
	output logic signed [SampleWidth-1:0] sample,
	output logic signed [SampleWidth-1:0] passOut,
	output opControl_t passControl
);
	logic [TableBits-1:0] modStep;
	logic [TableBits-1:0] mainIndex;
	logic [TableBits-1:0] halfIndex;
	// lookup stage
	logic stageValid;
	logic stageLast;
	logic signed [TableWidth-1:0] mainEntry;
	logic signed [TableWidth-1:0] halfEntry;
	logic [TableBits-1:0] stageIndex;
	logic stageHalfSel;
	opControl_t stageControl;
	logic signed [SampleWidth-1:0] stagePass;
	// shaping stage
	logic signed [TableWidth-1:0] shaped;
	logic signed [TableWidth-1:0] biasEntry;
	logic signed [SampleWidth-1:0] widened;
	logic signed [SampleWidth-1:0] attenuated;
	logic signed [SampleWidth-1:0] scaled;

	// modulation bends both indices by the same step
	assign modStep = control.field.modEnable ? modOffset[TableWidth-1 -: TableBits] : '0;
	assign mainIndex = phase[PhaseWidth-1 -: TableBits] + modStep;
	// half-period index runs at twice the rate
	assign halfIndex = phase[PhaseWidth-2 -: TableBits] + modStep;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			stageValid <= 1'b0;
			stageLast <= 1'b0;
			outValid <= 1'b0;
			outLast <= 1'b0;
		end
		else
		begin
			stageValid <= inValid;
			stageLast <= inLast;
			outValid <= stageValid;
			outLast <= stageLast;
		end
	end

	always_ff @(posedge clock)
	begin
		mainEntry <= sineTable[mainIndex];
		halfEntry <= sineTable[halfIndex];
		stageIndex <= mainIndex;
		stageHalfSel <= phase[PhaseWidth-2];
		stageControl <= control;
		stagePass <= passIn;
	end

	always_comb
	begin
		case (stageControl.field.waveform)
			WaveSine: shaped = mainEntry;
			WaveHalf: shaped = mainEntry[TableWidth-1] ? '0 : mainEntry;
			WaveFull: shaped = mainEntry[TableWidth-1] ? ~mainEntry : mainEntry;
			WaveGated: shaped = stageHalfSel ? '0 : mainEntry;
			WaveDouble: shaped = stageHalfSel ? '0 : halfEntry;
			WaveDoubleFull:
			begin
				if (stageHalfSel)
					shaped = '0;
				else
					shaped = halfEntry[TableWidth-1] ? ~halfEntry : halfEntry;
			end
			WaveSquare: shaped = mainEntry[TableWidth-1] ? 8'h80 : 8'h7F;
			// falling ramp, low bits refill from the top
			WaveRamp: shaped = {stageIndex[5], ~stageIndex[4:0], ~stageIndex[5:4]};
			default: shaped = mainEntry;
		endcase
	end

	// codes above 7 carry no bias
	assign biasEntry = stageControl.field.waveform[3] ? '0 :
		biasTable[stageControl.field.waveform[2:0]];

	// sign, 8 bit value, three zero bits
	assign widened = {shaped[TableWidth-1], shaped, 3'b000} -
		{biasEntry[TableWidth-1], biasEntry, 3'b000};

	// attenuation bits take off 1/8, 1/4, 1/2
	always_comb
	begin
		attenuated = widened;
		if (stageControl.field.attenuation[0])
			attenuated = attenuated - (widened >>> 3);
		if (stageControl.field.attenuation[1])
			attenuated = attenuated - (widened >>> 2);
		if (stageControl.field.attenuation[2])
			attenuated = attenuated - (widened >>> 1);
	end

	assign scaled = attenuated >>> stageControl.field.shift;

	always_ff @(posedge clock)
	begin
		sample <= scaled;
		passOut <= stagePass;
		passControl <= stageControl;
	end

	// frame end marker only rides on a valid entry
	lastWithValid: assert property (@(posedge clock) disable iff (reset)
		inLast |-> inValid);

endmodule

/* rtl/fmMixer.sv */
// channel combine, accumulation with overflow hold, saturation and pcm output register
`timescale 1ns/1ns

module fmMixer
	import fmSynthPkg::*;
(
	input logic clock,
	input logic reset,
	input logic channelValid,
	input logic channelLast,
	input logic signed [SampleWidth-1:0] carrierOut,
	input logic signed [SampleWidth-1:0] modulatorPass,
	input opControl_t control,
	output logic signed [SampleWidth-1:0] pcm,
	output logic pcmValid
);
	localparam int ExtendBits = AccumWidth - SampleWidth;

	logic signed [AccumWidth-1:0] channelValue;
	logic signed [AccumWidth-1:0] accum;
	logic signed [AccumWidth-1:0] accumSum;
	logic accumOverflow;
	logic accumSafe;
	logic framePending;
	logic signed [SampleWidth-1:0] pcmNext;

	always_comb
	begin
		channelValue = {{ExtendBits{carrierOut[SampleWidth-1]}}, carrierOut};
		// modulator is heard only when it does not modulate
		if (!control.field.modEnable)
			channelValue = channelValue +
				{{ExtendBits{modulatorPass[SampleWidth-1]}}, modulatorPass};
		// near-zero step means channel off
		if (control.field.freqStep[PhaseWidth-1:8] == '0)
			channelValue = '0;
	end

	// same-sign operands, sign flip on the sum
	assign accumSum = accum + channelValue;
	assign accumOverflow = (accum[AccumWidth-1] == channelValue[AccumWidth-1]) &&
		(accumSum[AccumWidth-1] != accum[AccumWidth-1]);

	// top four bits agree, so bits 12:1 hold the value
	assign accumSafe = (accum[AccumWidth-1 -: 4] == 4'h0) ||
		(accum[AccumWidth-1 -: 4] == 4'hF);
	assign pcmNext = accumSafe ? accum[SampleWidth:1] :
		(accum[AccumWidth-1] ? 12'h800 : 12'h7FF);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			accum <= '0;
			framePending <= 1'b0;
			pcm <= '0;
			pcmValid <= 1'b0;
		end
		else
		begin
			framePending <= channelValid && channelLast;
			pcmValid <= framePending;
			// last channel is in, publish and start over
			if (framePending)
			begin
				pcm <= pcmNext;
				accum <= '0;
			end
			else if (channelValid && !accumOverflow)
				accum <= accumSum;
		end
	end

endmodule

/* rtl/fmSynthTop.sv */
// top level of the two-operator fm tone generator, instances and wiring
`timescale 1ns/1ns

module fmSynthTop
	import fmSynthPkg::*;
(
	input logic clock,
	input logic reset,
	input logic sampleTick,
	input logic [8:0] address,
	input logic writeStrobe,
	input logic readStrobe,
	input logic [BusWidth-1:0] writeData,
	output logic [BusWidth-1:0] readData,
	output logic readValid,
	output logic signed [SampleWidth-1:0] pcm,
	output logic pcmValid
);
	// scan port between sequencer and storage
	logic [ChannelBits-1:0] scanChannel;
	opControl_t ctrlA;
	opControl_t ctrlB;
	logic [PhaseWidth-1:0] phaseA;
	logic [PhaseWidth-1:0] phaseB;
	// phase write-back
	logic phaseWriteEnable;
	logic [ChannelBits-1:0] phaseWriteChannel;
	logic [PhaseWidth-1:0] nextPhaseA;
	logic [PhaseWidth-1:0] nextPhaseB;
	// issue into the modulator
	logic issueValid;
	logic issueLast;
	opControl_t issueCtrlA;
	opControl_t issueCtrlB;
	logic [PhaseWidth-1:0] issuePhaseA;
	logic [PhaseWidth-1:0] issuePhaseB;
	// modulator to carrier
	logic modValid;
	logic modLast;
	logic signed [SampleWidth-1:0] modSample;
	// carrier to mixer
	logic channelValid;
	logic channelLast;
	logic signed [SampleWidth-1:0] carrierOut;
	logic signed [SampleWidth-1:0] modulatorPass;
	opControl_t mixControl;

	fmChannelRegs regs (
		.clock(clock),
		.reset(reset),
		.address(address),
		.writeStrobe(writeStrobe),
		.readStrobe(readStrobe),
		.writeData(writeData),
		.readData(readData),
		.readValid(readValid),
		.scanChannel(scanChannel),
		.ctrlA(ctrlA),
		.ctrlB(ctrlB),
		.phaseA(phaseA),
		.phaseB(phaseB),
		.phaseWriteEnable(phaseWriteEnable),
		.phaseWriteChannel(phaseWriteChannel),
		.nextPhaseA(nextPhaseA),
		.nextPhaseB(nextPhaseB)
	);

	fmChannelSequencer sequencer (
		.clock(clock),
		.reset(reset),
		.sampleTick(sampleTick),
		.scanValid(),
		.scanChannel(scanChannel),
		.ctrlA(ctrlA),
		.ctrlB(ctrlB),
		.phaseA(phaseA),
		.phaseB(phaseB),
		.issueValid(issueValid),
		.issueLast(issueLast),
		.issueCtrlA(issueCtrlA),
		.issueCtrlB(issueCtrlB),
		.issuePhaseA(issuePhaseA),
		.issuePhaseB(issuePhaseB),
		.phaseWriteEnable(phaseWriteEnable),
		.phaseWriteChannel(phaseWriteChannel),
		.nextPhaseA(nextPhaseA),
		.nextPhaseB(nextPhaseB)
	);

	// operator b, unmodulated
	fmOperator modulator (
		.clock(clock),
		.reset(reset),
		.inValid(issueValid),
		.inLast(issueLast),
		.control(issueCtrlB),
		.phase(issuePhaseB),
		.modOffset('0),
		.passIn('0),
		.outValid(modValid),
		.outLast(modLast),
		.sample(modSample),
		.passOut(),
		.passControl()
	);

	// operator a, modulated by the top byte of operator b
	fmOperator carrier (
		.clock(clock),
		.reset(reset),
		.inValid(modValid),
		.inLast(modLast),
		.control(issueCtrlA),
		.phase(issuePhaseA),
		.modOffset(modSample[SampleWidth-1 -: TableWidth]),
		.passIn(modSample),
		.outValid(channelValid),
		.outLast(channelLast),
		.sample(carrierOut),
		.passOut(modulatorPass),
		.passControl(mixControl)
	);

	fmMixer mixer (
		.clock(clock),
		.reset(reset),
		.channelValid(channelValid),
		.channelLast(channelLast),
		.carrierOut(carrierOut),
		.modulatorPass(modulatorPass),
		.control(mixControl),
		.pcm(pcm),
		.pcmValid(pcmValid)
	);

endmodule

/* tb/fmSynthModel.svh */
// reference model functions: operator shaping and scaling, channel value, whole-frame mix
`ifndef FM_SYNTH_MODEL_SVH
`define FM_SYNTH_MODEL_SVH

// one operator, modStep already cut down to a 6-bit table step
function automatic int operatorModel(input opControl_t control,
	input logic [PhaseWidth-1:0] phase, input int modStep);
	int mainIdx;
	int halfIdx;
	int mainV;
	int halfV;
	int shaped;
	int bias;
	int ramp;
	int widened;
	int level;
	logic halfSel;
	mainIdx = (int'(phase[19:14]) + modStep) % 64;
	halfIdx = (int'(phase[18:13]) + modStep) % 64;
	mainV = int'(sineTable[mainIdx]);
	halfV = int'(sineTable[halfIdx]);
	halfSel = phase[18];
	// falling ramp, index bits inverted and refilled
	ramp = (mainIdx / 32) * 128 + (31 - mainIdx % 32) * 4 + (3 - mainIdx / 16);
	if (ramp >= 128)
		ramp = ramp - 256;
	bias = 0;
	if (control.field.waveform < 4'd8)
		bias = int'(biasTable[control.field.waveform[2:0]]);
	case (control.field.waveform)
		WaveSine: shaped = mainV;
		WaveHalf: shaped = (mainV < 0) ? 0 : mainV;
		// one's complement on the negative half
		WaveFull: shaped = (mainV < 0) ? -mainV - 1 : mainV;
		WaveGated: shaped = halfSel ? 0 : mainV;
		WaveDouble: shaped = halfSel ? 0 : halfV;
		WaveDoubleFull: shaped = halfSel ? 0 : ((halfV < 0) ? -halfV - 1 : halfV);
		WaveSquare: shaped = (mainV < 0) ? -128 : 127;
		WaveRamp: shaped = ramp;
		default: shaped = mainV;
	endcase
	// value times eight, minus the bias times eight
	widened = (shaped - bias) * 8;
	level = widened;
	if (control.field.attenuation[0])
		level = level - (widened >>> 3);
	if (control.field.attenuation[1])
		level = level - (widened >>> 2);
	if (control.field.attenuation[2])
		level = level - (widened >>> 1);
	return level >>> control.field.shift;
endfunction

// modulator only heard when it does not modulate
function automatic int channelModel(input opControl_t ctrlAWord, input int carrierValue,
	input int modulatorValue);
	int value;
	value = carrierValue;
	if (!ctrlAWord.field.modEnable)
		value = value + modulatorValue;
	if (ctrlAWord.field.freqStep[19:8] == 12'h000)
		value = 0;
	return value;
endfunction

// pcm for one frame from pre-step phases
function automatic int frameModel(input opControl_t ctrlAList [ChannelCount],
	input opControl_t ctrlBList [ChannelCount],
	input logic [PhaseWidth-1:0] phaseAList [ChannelCount],
	input logic [PhaseWidth-1:0] phaseBList [ChannelCount]);
	int accum;
	int modValue;
	int carrierValue;
	int step;
	int value;
	accum = 0;
	for (int ch = 0; ch < ChannelCount; ch++)
	begin
		modValue = operatorModel(ctrlBList[ch], phaseBList[ch], 0);
		// bits 11:6 of the modulator sample
		step = ctrlAList[ch].field.modEnable ? ((modValue >>> 6) & 63) : 0;
		carrierValue = operatorModel(ctrlAList[ch], phaseAList[ch], step);
		value = channelModel(ctrlAList[ch], carrierValue, modValue);
		// an add that leaves the 16-bit range is dropped
		if (accum + value <= 32767 && accum + value >= -32768)
			accum = accum + value;
	end
	if (accum >= -4096 && accum <= 4095)
		return accum >>> 1;
	return (accum < 0) ? -2048 : 2047;
endfunction

`endif

/* tb/fmSynthTb.sv */
// testbench for the fm tone generator: clock, reset, watchdog, bus and frame tasks, directed tests
`timescale 1ns/1ns

module fmSynthTb
	import fmSynthPkg::*;
();
	localparam int ClockPeriod = 8;
	localparam int ResetCycles = 8;
	localparam int TestCount = 6;
	localparam int FramesPerTest = 160;
	localparam int CyclesPerFrame = 40;
	localparam int WatchdogCycles = TestCount * FramesPerTest * CyclesPerFrame;
	localparam int PcmTimeout = 100;

	logic clock;
	logic reset;
	logic sampleTick;
	logic [8:0] address;
	logic writeStrobe;
	logic readStrobe;
	logic [BusWidth-1:0] writeData;
	logic [BusWidth-1:0] readData;
	logic readValid;
	logic signed [SampleWidth-1:0] pcm;
	logic pcmValid;

	int errorCount;
	int checkCount;
	logic [31:0] randState;
	// what the host has written and where the phases should be
	opControl_t ctrlAShadow [ChannelCount];
	opControl_t ctrlBShadow [ChannelCount];
	logic [PhaseWidth-1:0] phaseAShadow [ChannelCount];
	logic [PhaseWidth-1:0] phaseBShadow [ChannelCount];

	`include "fmSynthModel.svh"

	fmSynthTop dut_i (
		.clock(clock),
		.reset(reset),
		.sampleTick(sampleTick),
		.address(address),
		.writeStrobe(writeStrobe),
		.readStrobe(readStrobe),
		.writeData(writeData),
		.readData(readData),
		.readValid(readValid),
		.pcm(pcm),
		.pcmValid(pcmValid)
	);

	initial
	begin
		clock = 1'b0;
		forever #(ClockPeriod / 2) clock = ~clock;
	end

	// bounded by the longest test times the test count
	initial
	begin
		repeat (WatchdogCycles) @(posedge clock);
		$display("timeout: run still going after %0d cycles", WatchdogCycles);
		$display("Checks failed");
		$finish;
	end

	function logic [31:0] nextRandom();
		randState = randState * 32'd1664525 + 32'd1013904223;
		return randState;
	endfunction

	function automatic logic [31:0] makeControl(input logic [3:0] waveform,
		input logic [2:0] shift, input logic [2:0] atten, input logic modEnable,
		input logic [PhaseWidth-1:0] step);
		opControl_t word;
		word.raw = '0;
		word.field.waveform = waveform;
		word.field.shift = shift;
		word.field.attenuation = atten;
		word.field.modEnable = modEnable;
		word.field.freqStep = step;
		return word.raw;
	endfunction

	task checkValue(input string what, input logic [31:0] got, input logic [31:0] expected);
		checkCount++;
		if (got !== expected)
		begin
			errorCount++;
			$display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, expected);
		end
	endtask

	task applyReset();
		reset <= 1'b1;
		repeat (ResetCycles) @(posedge clock);
		reset <= 1'b0;
		for (int ch = 0; ch < ChannelCount; ch++)
		begin
			ctrlAShadow[ch] = '0;
			ctrlBShadow[ch] = '0;
			phaseAShadow[ch] = '0;
			phaseBShadow[ch] = '0;
		end
	endtask

	task busWrite(input int channel, input logic [2:0] select, input logic [31:0] data);
		@(posedge clock);
		address <= {4'(channel), select, 2'b00};
		writeData <= data;
		writeStrobe <= 1'b1;
		@(posedge clock);
		writeStrobe <= 1'b0;
		if (select == RegCtrlA)
			ctrlAShadow[channel].raw = data;
		if (select == RegCtrlB)
			ctrlBShadow[channel].raw = data;
	endtask

	// data and readValid sampled mid-cycle
	task busRead(input int channel, input logic [2:0] select, output logic [31:0] data);
		@(posedge clock);
		address <= {4'(channel), select, 2'b00};
		readStrobe <= 1'b1;
		@(negedge clock);
		checkValue("readValid before the strobe is taken", 32'(readValid), 32'd0);
		@(posedge clock);
		readStrobe <= 1'b0;
		@(negedge clock);
		checkValue("readValid one cycle after the strobe", 32'(readValid), 32'd1);
		data = readData;
		@(negedge clock);
		checkValue("readValid lasts one cycle", 32'(readValid), 32'd0);
	endtask

	task silenceAll();
		for (int ch = 0; ch < ChannelCount; ch++)
		begin
			busWrite(ch, RegCtrlA, 32'd0);
			busWrite(ch, RegCtrlB, 32'd0);
		end
	endtask

	task pulseTick();
		@(posedge clock);
		sampleTick <= 1'b1;
		@(posedge clock);
		sampleTick <= 1'b0;
	endtask

	task waitForPcm(output logic signed [SampleWidth-1:0] value, output bit seen);
		int waited;
		seen = 1'b0;
		waited = 0;
		value = '0;
		while (!seen && waited < PcmTimeout)
		begin
			@(negedge clock);
			waited++;
			if (pcmValid)
			begin
				value = pcm;
				seen = 1'b1;
			end
		end
	endtask

	// every channel steps once per frame, wrapping at 2^20
	task advancePhases();
		for (int ch = 0; ch < ChannelCount; ch++)
		begin
			phaseAShadow[ch] = phaseAShadow[ch] + ctrlAShadow[ch].field.freqStep;
			phaseBShadow[ch] = phaseBShadow[ch] + ctrlBShadow[ch].field.freqStep;
		end
	endtask

	task runFrame(input string what);
		int expected;
		logic signed [SampleWidth-1:0] got;
		bit seen;
		expected = frameModel(ctrlAShadow, ctrlBShadow, phaseAShadow, phaseBShadow);
		pulseTick();
		waitForPcm(got, seen);
		if (!seen)
		begin
			errorCount++;
			$display("ERROR at %0t: no pcmValid within %0d cycles (%s)", $time, PcmTimeout, what);
		end
		else
			checkValue(what, 32'(got), 32'(expected));
		advancePhases();
	endtask

	task checkPhases(input string what);
		logic [31:0] word;
		for (int ch = 0; ch < ChannelCount; ch++)
		begin
			busRead(ch, RegPhaseA, word);
			checkValue({what, " phase A"}, word, 32'(phaseAShadow[ch]));
			busRead(ch, RegPhaseB, word);
			checkValue({what, " phase B"}, word, 32'(phaseBShadow[ch]));
		end
	endtask

	task testRegisterReadback();
		logic [31:0] word;
		for (int ch = 0; ch < ChannelCount; ch++)
		begin
			busWrite(ch, RegCtrlA, nextRandom());
			busWrite(ch, RegCtrlB, nextRandom());
		end
		for (int ch = 0; ch < ChannelCount; ch++)
		begin
			busRead(ch, RegCtrlA, word);
			checkValue("control A read-back", word, ctrlAShadow[ch].raw);
			busRead(ch, RegCtrlB, word);
			checkValue("control B read-back", word, ctrlBShadow[ch].raw);
		end
		// phases are read-only and still zero
		busWrite(3, RegPhaseA, 32'hFFFF_FFFF);
		busWrite(3, RegPhaseB, 32'h000A_5A5A);
		busRead(3, RegPhaseA, word);
		checkValue("phase A after ignored write", word, 32'd0);
		busRead(3, RegPhaseB, word);
		checkValue("phase B after ignored write", word, 32'd0);
		for (int sel = 4; sel < 8; sel++)
		begin
			busRead(9, 3'(sel), word);
			checkValue("unused select reads zero", word, 32'd0);
		end
	endtask

	task testPhaseStep();
		localparam int FrameCount = 3;
		logic [PhaseWidth-1:0] startA [ChannelCount];
		logic [PhaseWidth-1:0] startB [ChannelCount];
		logic [31:0] word;
		startA = phaseAShadow;
		startB = phaseBShadow;
		repeat (FrameCount) runFrame("pcm while stepping phases");
		for (int ch = 0; ch < ChannelCount; ch++)
		begin
			busRead(ch, RegPhaseA, word);
			checkValue("phase A after N frames", word,
				32'(startA[ch] + 20'(FrameCount * ctrlAShadow[ch].field.freqStep)));
			busRead(ch, RegPhaseB, word);
			checkValue("phase B after N frames", word,
				32'(startB[ch] + 20'(FrameCount * ctrlBShadow[ch].field.freqStep)));
		end
	endtask

	// channel 0 alone, every waveform, shift and attenuation
	task testWaveforms();
		silenceAll();
		busWrite(0, RegCtrlB, makeControl(WaveSine, 3'd3, 3'd0, 1'b0, 20'h1D2B1));
		for (int wave = 0; wave < 8; wave++)
		begin
			for (int k = 0; k < 8; k++)
			begin
				busWrite(0, RegCtrlA,
					makeControl(4'(wave), 3'((k * 3) % 8), 3'(k), 1'b0, 20'h0A3C5));
				repeat (2) runFrame("single-channel waveform pcm");
			end
		end
	endtask

	task testModulation();
		logic [3:0] waves [3];
		waves = '{WaveSine, WaveFull, WaveRamp};
		silenceAll();
		busWrite(5, RegCtrlB, makeControl(WaveSine, 3'd0, 3'd0, 1'b0, 20'h0B311));
		for (int i = 0; i < 3; i++)
		begin
			busWrite(5, RegCtrlA, makeControl(waves[i], 3'd1, 3'd0, 1'b1, 20'h04A21));
			repeat (8) runFrame("fm modulated pcm");
		end
	endtask

	task testSaturation();
		logic [PhaseWidth-1:0] step;
		// zero phases, so the first frames hit both rails
		applyReset();
		for (int ch = 0; ch < ChannelCount; ch++)
		begin
			busWrite(ch, RegCtrlA, makeControl(WaveSquare, 3'd0, 3'd0, 1'b0, 20'h90000));
			busWrite(ch, RegCtrlB, makeControl(WaveSquare, 3'd0, 3'd0, 1'b0, 20'h90000));
		end
		repeat (4) runFrame("saturated square pcm");
		for (int ch = 0; ch < ChannelCount; ch++)
		begin
			step = PhaseWidth'(nextRandom()) | 20'h01000;
			busWrite(ch, RegCtrlA, makeControl(WaveSquare, 3'd0, 3'd0, 1'b0, step));
			busWrite(ch, RegCtrlB, makeControl(WaveSquare, 3'd0, 3'd0, 1'b0, ~step));
		end
		repeat (8) runFrame("square mix pcm");
		// gated negative quarter plus its bias runs past the 16-bit range
		applyReset();
		for (int ch = 0; ch < ChannelCount; ch++)
		begin
			busWrite(ch, RegCtrlA, makeControl(WaveGated, 3'd0, 3'd0, 1'b0, 20'hA8000));
			busWrite(ch, RegCtrlB, makeControl(WaveGated, 3'd0, 3'd0, 1'b0, 20'hA8000));
		end
		repeat (4) runFrame("overflow hold pcm");
	endtask

	task testIgnoredTick();
		int expected;
		int pulses;
		logic signed [SampleWidth-1:0] got;
		expected = frameModel(ctrlAShadow, ctrlBShadow, phaseAShadow, phaseBShadow);
		pulses = 0;
		got = '0;
		pulseTick();
		// second tick lands while the walk is running
		repeat (4) @(posedge clock);
		pulseTick();
		repeat (80)
		begin
			@(negedge clock);
			if (pcmValid)
			begin
				pulses++;
				got = pcm;
			end
		end
		checkValue("pcmValid pulses for two close ticks", 32'(pulses), 32'd1);
		checkValue("pcm with ignored tick", 32'(got), 32'(expected));
		advancePhases();
		checkPhases("single step after ignored tick");
	endtask

	initial
	begin
		reset = 1'b1;
		sampleTick = 1'b0;
		address = '0;
		writeStrobe = 1'b0;
		readStrobe = 1'b0;
		writeData = '0;
		errorCount = 0;
		checkCount = 0;
		randState = 32'd29;
		applyReset();
		testRegisterReadback();
		testPhaseStep();
		testWaveforms();
		testModulation();
		testSaturation();
		testIgnoredTick();
		$display("%0d checks run, %0d errors", checkCount, errorCount);
		if (errorCount == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

/* sources.f */
+incdir+tb
rtl/fmSynthPkg.sv
rtl/fmChannelRegs.sv
rtl/fmChannelSequencer.sv
rtl/fmOperator.sv
rtl/fmMixer.sv
rtl/fmSynthTop.sv
tb/fmSynthTb.sv

/* Makefile */
# Verilator build and run for the fm tone generator testbench

VERILATOR ?= verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = fmSynthTb
FILELIST = sources.f
BUILD = obj_dir
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "All checks passed" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
